// ==== Bender.yml ====
package:
  name: ssf_array

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/ssf_pkg.sv
      - source/ssf_launch.sv
      - source/ssf_worker.sv
      - source/ssf_input_arbiter.sv
      - source/ssf_result_collector.sv
      - source/ssf_array.sv
      - target: test
        files:
          - test/ssf_array_sva.sv
          - test/ssf_array_tb.sv

// ==== include/ssf_cfg.svh ====
`ifndef SSF_CFG_SVH
`define SSF_CFG_SVH

// Number of workers in the array, 2 to 24
`define SSF_WORKERS 4

// Cycles between two worker releases
`define SSF_STAGGER 40

`define SSF_BLOCK 4 // Samples per sum

`define SSF_FIFO_DEPTH 4 // Power of two

`endif

// ==== source/ssf_array.sv ====
`timescale 1ns/1ns
`include "ssf_cfg.svh"

module ssf_array (
	input  logic                clk,
	input  logic                rst_n,
	input  ssf_pkg::sample_t    io_in,
	input  logic                in_valid,
	output logic                req_strobe,
	output ssf_pkg::worker_id_t req_id,
	output logic                out_valid,
	output ssf_pkg::result_t    out_result
);

	logic [`SSF_WORKERS-1:0] run;
	logic [`SSF_WORKERS-1:0] req;
	logic [`SSF_WORKERS-1:0] grant;
	logic [`SSF_WORKERS-1:0] sample_valid;
	logic [`SSF_WORKERS-1:0] emit;
	logic [`SSF_WORKERS-1:0] ack;
	ssf_pkg::sample_t        sums [`SSF_WORKERS];

	ssf_launch launch_i (
		.clk (clk),
		.rst_n (rst_n),
		.run (run)
	);

	ssf_input_arbiter arbiter_i (
		.clk (clk),
		.rst_n (rst_n),
		.req (req),
		.in_valid (in_valid),
		.grant (grant),
		.sample_valid (sample_valid),
		.req_strobe (req_strobe),
		.req_id (req_id)
	);

	// Shared input bus, each worker only takes its routed strobe
	for (genvar i = 0; i < `SSF_WORKERS; i++) begin : gen_worker
		ssf_worker worker_i (
			.clk (clk),
			.rst_n (rst_n),
			.run (run[i]),
			.grant (grant[i]),
			.sample_valid (sample_valid[i]),
			.sample (io_in),
			.ack (ack[i]),
			.req (req[i]),
			.emit (emit[i]),
			.sum (sums[i])
		);
	end

	ssf_result_collector collector_i (
		.clk (clk),
		.rst_n (rst_n),
		.emit (emit),
		.sums (sums),
		.ack (ack),
		.out_valid (out_valid),
		.out_result (out_result)
	);

endmodule

// ==== source/ssf_input_arbiter.sv ====
`timescale 1ns/1ns
`include "ssf_cfg.svh"

module ssf_input_arbiter (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [`SSF_WORKERS-1:0] req,
	input  logic                    in_valid,
	output logic [`SSF_WORKERS-1:0] grant,
	output logic [`SSF_WORKERS-1:0] sample_valid,
	output logic                    req_strobe,
	output ssf_pkg::worker_id_t     req_id
);

	logic                pick_valid;
	ssf_pkg::worker_id_t pick_id;
	logic                outstanding;
	ssf_pkg::worker_id_t owner;

	// Lowest index wins, so scan downwards
	always_comb begin
		pick_valid = 1'b0;
		pick_id = '0;
		for (int i = `SSF_WORKERS - 1; i >= 0; i--) begin
			if (req[i]) begin
				pick_valid = 1'b1;
				pick_id = ssf_pkg::worker_id_t'(i);
			end
		end
	end

	assign req_strobe = pick_valid && !outstanding;
	assign req_id = req_strobe ? pick_id : '0;

	always_comb begin
		grant = '0;
		sample_valid = '0;
		for (int i = 0; i < `SSF_WORKERS; i++) begin
			grant[i] = req_strobe && (pick_id == ssf_pkg::worker_id_t'(i));
			sample_valid[i] = in_valid && outstanding && (owner == ssf_pkg::worker_id_t'(i));
		end
	end

	// One sample in flight at a time
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			outstanding <= 1'b0;
			owner <= '0;
		end else if (req_strobe) begin
			outstanding <= 1'b1;
			owner <= pick_id;
		end else if (in_valid) begin
			outstanding <= 1'b0;
		end
	end

endmodule

// ==== source/ssf_launch.sv ====
`timescale 1ns/1ns
`include "ssf_cfg.svh"

module ssf_launch (
	input  logic                    clk,
	input  logic                    rst_n,
	output logic [`SSF_WORKERS-1:0] run
);

	localparam int CNT_W = $clog2(`SSF_STAGGER + 1);

	logic [CNT_W-1:0] cnt;
	logic             all_run;

	assign all_run = &run;

	// Worker 0 goes on the first edge, the next one every stagger period
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			run <= '0;
			cnt <= '0;
		end else if (!all_run) begin
			if (cnt == '0) begin
				run <= {run[`SSF_WORKERS-2:0], 1'b1}; // Shift in the next run bit
			end
			if (cnt == CNT_W'(`SSF_STAGGER - 1)) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

endmodule

// ==== source/ssf_pkg.sv ====
package ssf_pkg;

	// Signed sample, also used for the wrapped sum
	typedef logic signed [31:0] sample_t;

	// Worker index, wide enough for 24 workers
	typedef logic [4:0] worker_id_t;

	// One finished sum and the worker that made it
	typedef struct packed {
		worker_id_t id;
		sample_t    sum;
	} result_t;

	typedef enum logic [1:0] {
		HOLD,      // Waiting for release
		REQUEST,
		WAIT_DATA,
		EMIT       // Sum held until ack
	} worker_state_t;

endpackage

// ==== source/ssf_result_collector.sv ====
`timescale 1ns/1ns
`include "ssf_cfg.svh"

module ssf_result_collector (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [`SSF_WORKERS-1:0] emit,
	input  ssf_pkg::sample_t        sums [`SSF_WORKERS],
	output logic [`SSF_WORKERS-1:0] ack,
	output logic                    out_valid,
	output ssf_pkg::result_t        out_result
);

	localparam int PTR_W = $clog2(`SSF_FIFO_DEPTH);
	localparam int CNT_W = $clog2(`SSF_FIFO_DEPTH + 1);

	logic                pick_valid;
	ssf_pkg::worker_id_t pick_id;
	ssf_pkg::sample_t    pick_sum;
	logic                full;
	logic                push;
	logic                pop;
	ssf_pkg::result_t    push_result;

	ssf_pkg::result_t    mem [`SSF_FIFO_DEPTH];
	logic [PTR_W-1:0]    wr_ptr;
	logic [PTR_W-1:0]    rd_ptr;
	logic [CNT_W-1:0]    count;

	// Fixed priority, lowest emitting index first
	always_comb begin
		pick_valid = 1'b0;
		pick_id = '0;
		pick_sum = '0;
		for (int i = `SSF_WORKERS - 1; i >= 0; i--) begin
			if (emit[i]) begin
				pick_valid = 1'b1;
				pick_id = ssf_pkg::worker_id_t'(i);
				pick_sum = sums[i];
			end
		end
	end

	assign full = (count == CNT_W'(`SSF_FIFO_DEPTH));
	assign push = pick_valid && !full; // Workers wait in EMIT while full
	assign pop = (count != '0);

	always_comb begin
		ack = '0;
		for (int i = 0; i < `SSF_WORKERS; i++) begin
			ack[i] = push && (pick_id == ssf_pkg::worker_id_t'(i));
		end
	end

	assign push_result.id = pick_id;
	assign push_result.sum = pick_sum;

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_result;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Head entry goes out straight from the storage registers, one per cycle
	assign out_valid = pop;
	assign out_result = mem[rd_ptr];

endmodule

// ==== source/ssf_worker.sv ====
`timescale 1ns/1ns
`include "ssf_cfg.svh"

module ssf_worker (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             run,
	input  logic             grant,
	input  logic             sample_valid,
	input  ssf_pkg::sample_t sample,
	input  logic             ack,
	output logic             req,
	output logic             emit,
	output ssf_pkg::sample_t sum
);

	localparam int CNT_W = $clog2(`SSF_BLOCK + 1);

	ssf_pkg::worker_state_t state;
	logic [CNT_W-1:0]       cnt;
	ssf_pkg::sample_t       acc;
	logic                   last;

	assign last = (cnt == CNT_W'(`SSF_BLOCK - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ssf_pkg::HOLD;
			req <= 1'b0;
			cnt <= '0;
			acc <= '0;
		end else begin
			case (state)
				ssf_pkg::HOLD: begin
					if (run) begin
						state <= ssf_pkg::REQUEST;
					end
				end

				// Request goes up one cycle after entry, held until grant
				ssf_pkg::REQUEST: begin
					if (grant) begin
						req <= 1'b0;
						state <= ssf_pkg::WAIT_DATA;
					end else begin
						req <= 1'b1;
					end
				end

				ssf_pkg::WAIT_DATA: begin
					if (sample_valid) begin
						acc <= acc + sample; // Wraps at 32 bits
						if (last) begin
							cnt <= '0;
							state <= ssf_pkg::EMIT;
						end else begin
							cnt <= cnt + 1'b1;
							state <= ssf_pkg::REQUEST;
						end
					end
				end

				ssf_pkg::EMIT: begin
					if (ack) begin
						acc <= '0; // Fresh block
						state <= ssf_pkg::REQUEST;
					end
				end

				default: begin
					state <= ssf_pkg::HOLD;
				end
			endcase
		end
	end

	assign emit = (state == ssf_pkg::EMIT);
	assign sum = acc;

endmodule

// ==== ssf_array.f ====
+incdir+include
source/ssf_pkg.sv
source/ssf_launch.sv
source/ssf_worker.sv
source/ssf_input_arbiter.sv
source/ssf_result_collector.sv
source/ssf_array.sv
test/ssf_array_sva.sv
test/ssf_array_tb.sv

// ==== test/ssf_array_sva.sv ====
`timescale 1ns/1ns
`include "ssf_cfg.svh"

module ssf_array_sva #(
	parameter bit SAMPLE_CHECKS = 1'b1 // Sample routing and strobe spacing
) (
	input logic                    clk,
	input logic                    rst_n,
	input logic [`SSF_WORKERS-1:0] sel,        // Grant or ack
	input logic [`SSF_WORKERS-1:0] data_valid, // Routed sample strobes
	input logic                    strobe
);

	sel_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(sel))
		else $error("select vector %b is not one-hot", sel);

	if (SAMPLE_CHECKS) begin : gen_sample
		// A routed sample belongs to the worker granted one cycle earlier
		data_follows_sel: assert property (@(posedge clk) disable iff (!rst_n)
			(|data_valid) |-> (data_valid == $past(sel)))
			else $error("sample_valid %b without a matching grant", data_valid);

		strobe_single: assert property (@(posedge clk) disable iff (!rst_n)
			strobe |=> !strobe)
			else $error("req_strobe high in two adjacent cycles");
	end

endmodule

bind ssf_input_arbiter ssf_array_sva arbiter_sva_i (
	.clk (clk),
	.rst_n (rst_n),
	.sel (grant),
	.data_valid (sample_valid),
	.strobe (req_strobe)
);

// Collector has no sample path, only the ack check applies
bind ssf_result_collector ssf_array_sva #(.SAMPLE_CHECKS(1'b0)) collector_sva_i (
	.clk (clk),
	.rst_n (rst_n),
	.sel (ack),
	.data_valid ('0),
	.strobe (1'b0)
);

// ==== test/ssf_array_tb.sv ====
`timescale 1ns/1ns
`include "ssf_cfg.svh"

module ssf_array_tb;

	localparam int N = `SSF_WORKERS;
	localparam int BLOCKS = 6 * `SSF_WORKERS; // Blocks to issue in total
	localparam int LIMIT = N * `SSF_STAGGER + 3 * `SSF_BLOCK * BLOCKS + 200;
	localparam int DRAIN = N + `SSF_FIFO_DEPTH + 4; // Pending sums leave within this
	localparam int T_RESET = 0;
	localparam int T_RELEASE = 1;
	localparam int T_PRIORITY = 2;
	localparam int T_SUMS = 3;
	localparam int T_COMPLETE = 4;

	logic                clk;
	logic                rst_n;
	ssf_pkg::sample_t    io_in;
	logic                in_valid;
	logic                req_strobe;
	ssf_pkg::worker_id_t req_id;
	logic                out_valid;
	ssf_pkg::result_t    out_result;

	ssf_pkg::sample_t model_sum [N];
	int               model_cnt [N];
	ssf_pkg::result_t exp_q [$];
	logic             waiting [N];    // Known to hold req high
	int               ready_at [N];
	logic             result_due [N];
	int               first_req [N];

	int cyc = 0;
	int cycles = 0;
	int blocks_issued = 0;
	int results_seen = 0;
	bit source_on = 1'b1;
	bit release_done = 1'b0;
	int checks = 0;
	int errors = 0;
	int test_err [5];

	ssf_array dut_i (
		.clk (clk),
		.rst_n (rst_n),
		.io_in (io_in),
		.in_valid (in_valid),
		.req_strobe (req_strobe),
		.req_id (req_id),
		.out_valid (out_valid),
		.out_result (out_result)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= LIMIT) begin
			$display("Timeout after %0d cycles with %0d of %0d results seen",
				cycles, results_seen, BLOCKS);
			$display("TEST FAIL");
			$finish;
		end
	end

	task automatic note_error(input int t);
		errors++;
		test_err[t]++;
	endtask

	task automatic report_test(input string name, input int t);
		$display("[%0t] %s: %s, %0d errors", $time, name,
			(test_err[t] == 0) ? "passed" : "failed", test_err[t]);
	endtask

	task automatic check_idle();
		checks += 2;
		assert (out_valid == 1'b0) else begin
			$display("ERROR t=%0t out_valid: expected 0, got %b", $time, out_valid);
			note_error(T_RESET);
		end
		assert (req_strobe == 1'b0) else begin
			$display("ERROR t=%0t req_strobe: expected 0, got %b", $time, req_strobe);
			note_error(T_RESET);
		end
	endtask

	// First request of worker k, internal level or grant at the port
	task automatic track_release();
		int seen;
		seen = 0;
		for (int k = 0; k < N; k++) begin
			if (first_req[k] < 0 && (dut_i.req[k] || (req_strobe && int'(req_id) == k))) begin
				first_req[k] = cyc;
				checks++;
				assert (cyc > k * `SSF_STAGGER) else begin
					$display("Worker %0d requested at cycle %0d, before its release at %0d",
						k, cyc, k * `SSF_STAGGER);
					note_error(T_RELEASE);
				end
			end
			if (first_req[k] >= 0)
				seen++;
		end
		if (!release_done && seen == N) begin
			release_done = 1'b1;
			report_test("staggered release", T_RELEASE);
		end
	endtask

	task automatic check_priority();
		for (int w = 0; w < N; w++) begin
			if (waiting[w] && cyc >= ready_at[w]) begin
				checks++;
				assert (int'(req_id) <= w) else begin
					$display("ERROR t=%0t req_id: expected <= %0d, got %0d", $time, w, req_id);
					note_error(T_PRIORITY);
				end
			end
		end
	endtask

	task automatic answer_request(input int w);
		ssf_pkg::sample_t s;
		ssf_pkg::result_t r;
		s = ssf_pkg::sample_t'($urandom);
		in_valid <= 1'b1;
		io_in <= s;
		model_sum[w] = model_sum[w] + s; // Wraps like the hardware
		model_cnt[w]++;
		if (model_cnt[w] == `SSF_BLOCK) begin
			r.id = ssf_pkg::worker_id_t'(w);
			r.sum = model_sum[w];
			exp_q.push_back(r);
			model_sum[w] = '0;
			model_cnt[w] = 0;
			result_due[w] = 1'b1;
			blocks_issued++;
			if (blocks_issued == BLOCKS)
				source_on = 1'b0;
		end else begin
			waiting[w] = 1'b1;
			ready_at[w] = cyc + 3; // Sample, REQUEST entry, then req
		end
	endtask

	task automatic check_result();
		int idx;
		int w;
		idx = -1;
		w = int'(out_result.id);
		for (int i = exp_q.size() - 1; i >= 0; i--) begin
			if (exp_q[i].id == out_result.id)
				idx = i;
		end
		results_seen++;
		checks++;
		assert (idx >= 0) else begin
			$display("Unexpected result from worker %0d with sum %h at %0t",
				w, out_result.sum, $time);
			note_error(T_COMPLETE);
		end
		if (idx >= 0) begin
			checks++;
			assert (out_result.sum == exp_q[idx].sum) else begin
				$display("ERROR t=%0t out_result.sum (worker %0d): expected %h, got %h",
					$time, w, exp_q[idx].sum, out_result.sum);
				note_error(T_SUMS);
			end
			exp_q.delete(idx);
			if (result_due[w]) begin
				result_due[w] = 1'b0;
				waiting[w] = 1'b1; // Acked at least one cycle ago
				ready_at[w] = cyc + 1;
			end
		end
	endtask

	always @(posedge clk) begin
		if (!rst_n) begin
			check_idle();
			in_valid <= 1'b0;
		end else begin
			cyc++;
			if (cyc == 1) begin
				check_idle();
				report_test("reset state", T_RESET);
			end
			track_release();
			in_valid <= 1'b0;
			io_in <= ssf_pkg::sample_t'($urandom); // Junk between samples
			if (req_strobe) begin
				checks++;
				assert (int'(req_id) < N) else begin
					$display("ERROR t=%0t req_id: expected < %0d, got %0d", $time, N, req_id);
					note_error(T_PRIORITY);
				end
				if (int'(req_id) < N) begin
					check_priority();
					waiting[req_id] = 1'b0;
					result_due[req_id] = 1'b0;
					if (source_on)
						answer_request(int'(req_id));
				end
			end
			if (out_valid)
				check_result();
		end
	end

	initial begin
		void'($urandom(32'he14d_3019));
		rst_n = 1'b0;
		in_valid = 1'b0;
		io_in = '0;
		for (int k = 0; k < N; k++) begin
			model_sum[k] = '0;
			model_cnt[k] = 0;
			waiting[k] = 1'b0;
			ready_at[k] = 0;
			result_due[k] = 1'b0;
			first_req[k] = -1;
		end
		for (int t = 0; t < 5; t++)
			test_err[t] = 0;
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		while (source_on)
			@(negedge clk);
		for (int i = 0; i < DRAIN && exp_q.size() != 0; i++)
			@(negedge clk);
		repeat (`SSF_FIFO_DEPTH + 2) @(negedge clk); // Catch stray results
		if (!release_done) begin
			for (int k = 0; k < N; k++) begin
				checks++;
				assert (first_req[k] >= 0) else begin
					$display("Worker %0d never raised a request", k);
					note_error(T_RELEASE);
				end
			end
			report_test("staggered release", T_RELEASE);
		end
		report_test("request priority", T_PRIORITY);
		report_test("block sums", T_SUMS);
		checks++;
		assert (exp_q.size() == 0) else begin
			$display("%0d expected results never reached the output", exp_q.size());
			note_error(T_COMPLETE);
		end
		report_test("completeness", T_COMPLETE);
		$display("Checks %0d, errors %0d, results %0d, blocks issued %0d",
			checks, errors, results_seen, blocks_issued);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule
